// ==== rtl/cpuPkg.sv ====
package cpuPkg;

  // ======================================================================
  // widths
  // ======================================================================
  localparam int dataWidth = 32;
  localparam int regCount = 16;
  localparam int flagsReg = 1; // compare flags live here.

  typedef logic [dataWidth-1:0] wordT;
  typedef logic [$clog2(regCount)-1:0] regIdxT;

  // ======================================================================
  // encodings
  // ======================================================================
  typedef enum logic [5:0] {
    opMove = 6'd1, opLoadImm = 6'd2, opLoadReg = 6'd3, opLoadIdx = 6'd4,
    opLoadAbs = 6'd6, opStoreAbs = 6'd7, opStoreIdx = 6'd8,
    opCmp = 6'd13, opCmpImm = 6'd14,
    opSetEq = 6'd15, opSetNe = 6'd16, opSetLt = 6'd17, opSetGt = 6'd18,
    opJump = 6'd19, opJumpFlagClr = 6'd20, opJumpFlagSet = 6'd21,
    opJumpZero = 6'd22, opJumpNonZero = 6'd23,
    opAddImm = 6'd28, opAdd = 6'd29, opSubImm = 6'd30, opSub = 6'd31,
    opInc = 6'd33, opDec = 6'd34, opShl = 6'd35, opShr = 6'd36, opNeg = 6'd37,
    opMulAdd = 6'd55
  } opcodeT;

  typedef enum logic [1:0] {msError = 2'd0, msBusy = 2'd1, msDone = 2'd2} memStatusT;

  typedef enum logic [1:0] {
    hcFetch = 2'd0, hcDataWord = 2'd1, hcAccess = 2'd2, hcIllegal = 2'd3
  } haltCodeT;

  typedef enum logic [2:0] {
    stFetch, stFetchWait, stOperands, stDataWait,
    stMemRequest, stMemWait, stWriteback, stHalt
  } seqStateT;

  // instruction word, register fields use their low nibble only.
  typedef struct packed {
    logic [7:0] rs2;
    logic [7:0] rs1;
    logic [7:0] rd;
    logic [1:0] spare;
    opcodeT opcode;
  } instrT;

  typedef struct packed {
    logic read;
    logic write;
    wordT addr;
    wordT wdata;
  } memReqT;

  typedef struct packed {
    memStatusT status;
    wordT rdata;
  } memRspT;

  // opcodes followed by an immediate data word.
  function automatic logic hasDataWord(opcodeT op);
    case (op)
      opLoadImm, opLoadIdx, opLoadAbs, opStoreAbs, opStoreIdx, opCmpImm,
      opJump, opJumpFlagClr, opJumpFlagSet, opJumpZero, opJumpNonZero,
      opAddImm, opSubImm, opMulAdd: hasDataWord = 1'b1;
      default: hasDataWord = 1'b0;
    endcase
  endfunction

endpackage

// ==== rtl/cpuRegFile.sv ====
`timescale 1ns/1ps

module cpuRegFile import cpuPkg::*; (
  input  logic   clk,
  input  logic   arstN,
  input  regIdxT rdIdx1,
  input  regIdxT rdIdx2,
  input  regIdxT rdIdx3,
  input  logic   wrEn,
  input  regIdxT wrIdx,
  input  wordT   wrData,
  input  logic   flagsWrEn,
  input  wordT   flagsData,
  output wordT   rdData1,
  output wordT   rdData2,
  output wordT   rdData3,
  output wordT   flags
);

  wordT regs [regCount];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < regCount; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wrEn) regs[wrIdx] <= wrData;
      if (flagsWrEn) regs[flagsReg] <= flagsData; // last assignment wins.
    end
  end

  assign rdData1 = regs[rdIdx1];
  assign rdData2 = regs[rdIdx2];
  assign rdData3 = regs[rdIdx3];
  assign flags   = regs[flagsReg];

endmodule

// ==== rtl/cpuExecute.sv ====
`timescale 1ns/1ps

module cpuExecute import cpuPkg::*; (
  input  instrT instr,
  input  wordT  opA,
  input  wordT  opB,
  input  wordT  opC,
  input  wordT  dataWord,
  input  wordT  loadValue,
  input  wordT  flags,
  input  wordT  ip,
  output wordT  result,
  output wordT  flagsNext,
  output logic  writesFlags,
  output wordT  memAddr,
  output logic  jumpTaken,
  output wordT  nextIp
);

  wordT cmpRhs;

  // ======================================================================
  // results
  // ======================================================================
  always_comb begin
    case (instr.opcode)
      opMove:    result = opB;
      opLoadImm: result = dataWord;
      opLoadReg, opLoadIdx, opLoadAbs: result = loadValue;
      opSetEq:   result = wordT'(opB == opC);
      opSetNe:   result = wordT'(opB != opC);
      opSetLt:   result = wordT'(opB < opC);
      opSetGt:   result = wordT'(opB > opC);
      opAddImm:  result = opB + dataWord;
      opAdd:     result = opB + opC;
      opSubImm:  result = opB - dataWord;
      opSub:     result = opB - opC;
      opInc:     result = opA + 32'd1;
      opDec:     result = opA - 32'd1;
      opShl:     result = opB << opC[4:0];
      opShr:     result = opB >> opC[4:0];
      opNeg:     result = -opB;
      opMulAdd:  result = opB + dataWord * opC;
      default:   result = '0;
    endcase
  end

  // unsigned compare, bit 0 equal, bit 1 less, bit 2 greater.
  assign cmpRhs      = (instr.opcode == opCmpImm) ? dataWord : opB;
  assign flagsNext   = {29'd0, opA > cmpRhs, opA < cmpRhs, opA == cmpRhs};
  assign writesFlags = (instr.opcode == opCmp) || (instr.opcode == opCmpImm);

  // ======================================================================
  // addresses and control flow
  // ======================================================================
  always_comb begin
    case (instr.opcode)
      opLoadReg:  memAddr = opB;
      opLoadIdx:  memAddr = dataWord + opB;
      opStoreIdx: memAddr = dataWord + opA;
      default:    memAddr = dataWord; // absolute forms.
    endcase
  end

  always_comb begin
    case (instr.opcode)
      opJumpFlagClr: jumpTaken = !flags[0];
      opJumpFlagSet: jumpTaken = flags[0];
      opJumpZero:    jumpTaken = (opA == '0);
      opJumpNonZero: jumpTaken = (opA != '0);
      default:       jumpTaken = 1'b0;
    endcase
  end

  always_comb begin
    if (instr.opcode == opJump || jumpTaken) begin
      nextIp = dataWord;
    end else if (hasDataWord(instr.opcode)) begin
      nextIp = ip + 32'd8;
    end else begin
      nextIp = ip + 32'd4;
    end
  end

endmodule

// ==== rtl/cpuSequencer.sv ====
`timescale 1ns/1ps

module cpuSequencer import cpuPkg::*; (
  input  logic     clk,
  input  logic     arstN,
  input  memRspT   memRsp,
  input  wordT     result,
  input  wordT     flagsNext,
  input  logic     writesFlags,
  input  wordT     memAddr,
  input  logic     jumpTaken,
  input  wordT     nextIp,
  input  wordT     rdData1,
  input  wordT     rdData2,
  input  wordT     rdData3,
  output memReqT   memReq,
  output instrT    instr,
  output wordT     opA,
  output wordT     opB,
  output wordT     opC,
  output wordT     dataWord,
  output wordT     loadValue,
  output wordT     ip,
  output regIdxT   rdIdx1,
  output regIdxT   rdIdx2,
  output regIdxT   rdIdx3,
  output logic     wrEn,
  output regIdxT   wrIdx,
  output wordT     wrData,
  output logic     flagsWrEn,
  output logic     halted,
  output haltCodeT haltCode,
  output wordT     haltData
);

  seqStateT state;
  logic reqActive;
  logic rspDone;
  logic rspError;

  function automatic logic isLegal(opcodeT op);
    case (op)
      opMove, opLoadImm, opLoadReg, opLoadIdx, opLoadAbs, opStoreAbs, opStoreIdx,
      opCmp, opCmpImm, opSetEq, opSetNe, opSetLt, opSetGt,
      opJump, opJumpFlagClr, opJumpFlagSet, opJumpZero, opJumpNonZero,
      opAddImm, opAdd, opSubImm, opSub, opInc, opDec, opShl, opShr, opNeg,
      opMulAdd: isLegal = 1'b1;
      default: isLegal = 1'b0;
    endcase
  endfunction

  function automatic logic isLoad(opcodeT op);
    isLoad = (op == opLoadReg) || (op == opLoadIdx) || (op == opLoadAbs);
  endfunction

  function automatic logic isStore(opcodeT op);
    isStore = (op == opStoreAbs) || (op == opStoreIdx);
  endfunction

  function automatic logic writesRd(opcodeT op);
    case (op)
      opMove, opLoadImm, opLoadReg, opLoadIdx, opLoadAbs,
      opSetEq, opSetNe, opSetLt, opSetGt, opAddImm, opAdd, opSubImm, opSub,
      opInc, opDec, opShl, opShr, opNeg, opMulAdd: writesRd = 1'b1;
      default: writesRd = 1'b0;
    endcase
  endfunction

  // status is not valid yet in the cycle the request is on the bus.
  assign reqActive = memReq.read || memReq.write;
  assign rspDone   = !reqActive && (memRsp.status == msDone);
  assign rspError  = !reqActive && (memRsp.status == msError);

  // ======================================================================
  // state machine
  // ======================================================================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state    <= stFetch;
      ip       <= '0;
      memReq   <= '0;
      haltCode <= hcFetch;
      haltData <= '0;
    end else begin
      memReq.read  <= 1'b0; // requests last one cycle.
      memReq.write <= 1'b0;
      case (state)
        stFetch: begin
          memReq.read <= 1'b1;
          memReq.addr <= ip;
          state       <= stFetchWait;
        end
        stFetchWait: begin
          if (rspDone) begin
            state <= stOperands;
          end else if (rspError) begin
            state    <= stHalt;
            haltCode <= hcFetch;
            haltData <= memReq.addr;
          end
        end
        stOperands: begin
          if (!isLegal(instr.opcode)) begin
            state    <= stHalt;
            haltCode <= hcIllegal;
            haltData <= ip;
          end else if (hasDataWord(instr.opcode)) begin
            memReq.read <= 1'b1;
            memReq.addr <= ip + 32'd4;
            state       <= stDataWait;
          end else if (isLoad(instr.opcode) || isStore(instr.opcode)) begin
            state <= stMemRequest;
          end else begin
            state <= stWriteback;
          end
        end
        stDataWait: begin
          if (rspDone) begin
            if (isLoad(instr.opcode) || isStore(instr.opcode)) state <= stMemRequest;
            else state <= stWriteback;
          end else if (rspError) begin
            state    <= stHalt;
            haltCode <= hcDataWord;
            haltData <= memReq.addr;
          end
        end
        stMemRequest: begin
          memReq.read  <= isLoad(instr.opcode);
          memReq.write <= isStore(instr.opcode);
          memReq.addr  <= memAddr;
          memReq.wdata <= opB; // store data comes from rs1.
          state        <= stMemWait;
        end
        stMemWait: begin
          if (rspDone) begin
            state <= stWriteback;
          end else if (rspError) begin
            state    <= stHalt;
            haltCode <= hcAccess;
            haltData <= memReq.addr;
          end
        end
        stWriteback: begin
          ip    <= nextIp;
          state <= stFetch;
        end
        default: state <= stHalt; // halted until reset.
      endcase
    end
  end

  // instruction and operand latches.
  always_ff @(posedge clk) begin
    if (state == stFetchWait && rspDone) instr <= instrT'(memRsp.rdata);
    if (state == stOperands) begin
      opA <= rdData1;
      opB <= rdData2;
      opC <= rdData3;
    end
    if (state == stDataWait && rspDone) dataWord <= memRsp.rdata;
    if (state == stMemWait && rspDone) loadValue <= memRsp.rdata;
  end

  assign rdIdx1    = instr.rd[3:0];
  assign rdIdx2    = instr.rs1[3:0];
  assign rdIdx3    = instr.rs2[3:0];
  assign wrIdx     = instr.rd[3:0];
  assign wrEn      = (state == stWriteback) && writesRd(instr.opcode);
  assign flagsWrEn = (state == stWriteback) && writesFlags;
  assign wrData    = writesFlags ? flagsNext : result; // shared by both write ports.
  assign halted    = (state == stHalt);

endmodule

// ==== rtl/cpuCore.sv ====
`timescale 1ns/1ps

module cpuCore import cpuPkg::*; (
  input  logic     clk,
  input  logic     arstN,
  input  memRspT   memRsp,
  output memReqT   memReq,
  output logic     halted,
  output haltCodeT haltCode,
  output wordT     haltData
);

  instrT  instr;
  wordT   opA, opB, opC;
  wordT   dataWord, loadValue, ip;
  regIdxT rdIdx1, rdIdx2, rdIdx3, wrIdx;
  logic   wrEn, flagsWrEn;
  wordT   wrData;
  wordT   rdData1, rdData2, rdData3, flags;
  wordT   result, flagsNext, memAddr, nextIp;
  logic   writesFlags, jumpTaken;

  // ======================================================================
  // control
  // ======================================================================
  cpuSequencer uSequencer (
    .clk(clk), .arstN(arstN), .memRsp(memRsp),
    .result(result), .flagsNext(flagsNext), .writesFlags(writesFlags),
    .memAddr(memAddr), .jumpTaken(jumpTaken), .nextIp(nextIp),
    .rdData1(rdData1), .rdData2(rdData2), .rdData3(rdData3),
    .memReq(memReq), .instr(instr), .opA(opA), .opB(opB), .opC(opC),
    .dataWord(dataWord), .loadValue(loadValue), .ip(ip),
    .rdIdx1(rdIdx1), .rdIdx2(rdIdx2), .rdIdx3(rdIdx3),
    .wrEn(wrEn), .wrIdx(wrIdx), .wrData(wrData), .flagsWrEn(flagsWrEn),
    .halted(halted), .haltCode(haltCode), .haltData(haltData)
  );

  // ======================================================================
  // datapath
  // ======================================================================
  cpuRegFile uRegFile (
    .clk(clk), .arstN(arstN),
    .rdIdx1(rdIdx1), .rdIdx2(rdIdx2), .rdIdx3(rdIdx3),
    .wrEn(wrEn), .wrIdx(wrIdx), .wrData(wrData),
    .flagsWrEn(flagsWrEn), .flagsData(wrData), // compares put flags on wrData.
    .rdData1(rdData1), .rdData2(rdData2), .rdData3(rdData3), .flags(flags)
  );

  cpuExecute uExecute (
    .instr(instr), .opA(opA), .opB(opB), .opC(opC),
    .dataWord(dataWord), .loadValue(loadValue), .flags(flags), .ip(ip),
    .result(result), .flagsNext(flagsNext), .writesFlags(writesFlags),
    .memAddr(memAddr), .jumpTaken(jumpTaken), .nextIp(nextIp)
  );

endmodule

// ==== verification/cpuCore_asserts.sv ====
`timescale 1ns/1ps

module cpuCore_asserts import cpuPkg::*; (
  input logic   clk,
  input logic   arstN,
  input memReqT memReq,
  input logic   halted
);

  // ====================================================================
  // memory handshake and halt
  // ====================================================================
  readWriteExclusive: assert property (@(posedge clk) disable iff (!arstN)
    !(memReq.read && memReq.write))
    else $error("read and write requested in the same cycle");

  quietWhenHalted: assert property (@(posedge clk) disable iff (!arstN)
    halted |-> !(memReq.read || memReq.write))
    else $error("memory request issued while halted");

  singleCycleRequest: assert property (@(posedge clk) disable iff (!arstN)
    (memReq.read || memReq.write) |=> !(memReq.read || memReq.write))
    else $error("memory request held longer than one cycle");

  haltSticky: assert property (@(posedge clk) disable iff (!arstN)
    halted |=> halted)
    else $error("core left halt without reset");

endmodule

bind cpuCore cpuCore_asserts uAsserts (
  .clk(clk), .arstN(arstN), .memReq(memReq), .halted(halted)
);

// ==== verification/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb import cpuPkg::*; ();

  logic     clk = 1'b0;
  logic     arstN;
  memRspT   memRsp;
  memReqT   memReq;
  logic     halted;
  haltCodeT haltCode;
  wordT     haltData;

  logic [31:0] mem [1024]; // 4 KB with the program below 0x800 and data above.
  logic [31:0] readQ [$];
  logic [31:0] storeAddrQ [$];
  logic [31:0] storeDataQ [$];
  logic [31:0] lfsr = 32'hff1c_a01c;
  logic [31:0] pc;
  logic [31:0] nextStore = 32'hC00;
  logic [31:0] errAddr;
  logic [31:0] pendAddr;
  bit pending = 1'b0;
  int waitCnt;
  int instrCount = 0;
  int cycles = 0;
  int cycleLimit = 0;

  opcodeT aluOps [15] = '{opMove, opAddImm, opAdd, opSubImm, opSub, opInc, opDec, opShl,
    opShr, opNeg, opMulAdd, opSetEq, opSetNe, opSetLt, opSetGt};
  opcodeT jumpOps [4] = '{opJumpFlagClr, opJumpFlagSet, opJumpZero, opJumpNonZero};

  cpuCore u_cpuCore (
    .clk(clk), .arstN(arstN), .memRsp(memRsp), .memReq(memReq),
    .halted(halted), .haltCode(haltCode), .haltData(haltData)
  );

  always #50 clk = ~clk;

  // ====================================================================
  // helpers
  // ====================================================================
  task automatic failRun();
    $display("Result: FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check(logic [31:0] got, logic [31:0] exp, string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      failRun();
    end
  endtask

  function automatic logic [31:0] lfsrStep(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] randBits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrStep(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] fillWord(logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'h3c5a_96e1;
  endfunction

  function automatic bit twoWord(logic [5:0] op);
    return op inside {opLoadImm, opLoadIdx, opLoadAbs, opStoreAbs, opStoreIdx, opCmpImm,
      opJump, opJumpFlagClr, opJumpFlagSet, opJumpZero, opJumpNonZero,
      opAddImm, opSubImm, opMulAdd};
  endfunction

  // operand a comes from rd, b from rs1 and c from rs2.
  // flags hold unsigned eq, lt and gt in bits 0 to 2.
  function automatic logic [31:0] refResult(opcodeT op, logic [31:0] a, logic [31:0] b,
                                            logic [31:0] c, logic [31:0] imm);
    logic [31:0] rhs;
    rhs = (op == opCmpImm) ? imm : b;
    case (op)
      opMove:   return b;
      opAddImm: return b + imm;
      opAdd:    return b + c;
      opSubImm: return b - imm;
      opSub:    return b - c;
      opInc:    return a + 32'd1;
      opDec:    return a - 32'd1;
      opShl:    return b << c[4:0];
      opShr:    return b >> c[4:0];
      opNeg:    return -b;
      opMulAdd: return b + imm * c;
      opSetEq:  return {31'd0, b == c};
      opSetNe:  return {31'd0, b != c};
      opSetLt:  return {31'd0, b < c};
      opSetGt:  return {31'd0, b > c};
      opCmp, opCmpImm: return {29'd0, a > rhs, a < rhs, a == rhs};
      default:  return 'x;
    endcase
  endfunction

  // live words lie on the executed path and are expected as reads.
  task automatic putWord(logic [31:0] w, bit live);
    mem[pc[11:2]] = w;
    if (live) readQ.push_back(pc);
    pc += 32'd4;
  endtask

  task automatic emit(logic [5:0] op, int rd, int rs1, int rs2, logic [31:0] imm, bit live);
    if (live) instrCount++;
    putWord({8'(rs2), 8'(rs1), 8'(rd), 2'b00, op}, live);
    if (twoWord(op)) putWord(imm, live);
  endtask

  task automatic loadImm(int rd, logic [31:0] value);
    emit(opLoadImm, rd, 0, 0, value, 1'b1);
  endtask

  task automatic expectStore(logic [31:0] addr, logic [31:0] data);
    storeAddrQ.push_back(addr);
    storeDataQ.push_back(data);
  endtask

  task automatic storeTo(int rs, logic [31:0] data, bit live);
    emit(opStoreAbs, 0, rs, 0, nextStore, live);
    if (live) expectStore(nextStore, data);
    nextStore += 32'd4;
  endtask

  task automatic runProgram(haltCodeT expCode, logic [31:0] expData);
    cycles = 0;
    cycleLimit = 40 * instrCount;
    @(posedge clk);
    #1;
    arstN = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    check(memReq.read, 1'b0, "read during reset");
    check(memReq.write, 1'b0, "write during reset");
    check(halted, 1'b0, "halted during reset");
    cycles = 0;
    arstN = 1'b1;
    @(posedge clk);
    #1;
    check(memReq.read, 1'b1, "first fetch after reset");
    check(memReq.addr, '0, "first fetch address");
    while (!halted) begin
      @(posedge clk);
      #1;
    end
    check(haltCode, expCode, "halt code");
    check(haltData, expData, "halt data");
    repeat (5) begin // memory model flags any late request.
      @(posedge clk);
      #1;
      check(halted, 1'b1, "halted held until reset");
    end
    if (readQ.size() != 0 || storeAddrQ.size() != 0) begin
      $display("error at %0t: core halted before all expected reads and stores", $time);
      failRun();
    end
    instrCount = 0;
  endtask

  // ====================================================================
  // memory model and store checker
  // ====================================================================
  always @(posedge clk) begin
    #1;
    memRsp.status = msBusy;
    if (pending) begin
      waitCnt--;
      if (waitCnt == 0) begin
        pending = 1'b0;
        memRsp.status = (pendAddr == errAddr) ? msError : msDone;
        memRsp.rdata = mem[pendAddr[11:2]];
      end
    end
    if (memReq.read || memReq.write) begin
      if (halted || pending || (memReq.read && memReq.write) || memReq.addr > 32'hFFF) begin
        $display("error at %0t: request to %h while halted or busy, %s",
                 $time, memReq.addr, "with read and write together, or out of range");
        failRun();
      end else begin
        if (memReq.read && memReq.addr < 32'h800) begin
          if (readQ.size() == 0) begin
            $display("error at %0t: program read of %h was not expected", $time, memReq.addr);
            failRun();
          end else begin
            check(memReq.addr, readQ.pop_front(), "program read address");
          end
        end
        if (memReq.write) mem[memReq.addr[11:2]] = memReq.wdata;
        pending = 1'b1;
        pendAddr = memReq.addr;
        waitCnt = randBits(2) % 3 + 1; // answer after 1 to 3 cycles.
      end
    end
  end

  always @(posedge clk) begin
    #1;
    if (memReq.write) begin
      if (storeAddrQ.size() == 0) begin
        $display("error at %0t: store to %h was not expected", $time, memReq.addr);
        failRun();
      end else begin
        check(memReq.addr, storeAddrQ.pop_front(), "store address");
        check(memReq.wdata, storeDataQ.pop_front(), "store data");
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (arstN && cycles > cycleLimit) begin
      $display("error at %0t: run timed out after %0d cycles", $time, cycles);
      failRun();
    end
  end

  // ====================================================================
  // test programs
  // ====================================================================
  initial begin
    logic [31:0] a2, a3, a4, imm, aB, rB, rhs, flags, addr, off;
    opcodeT cmpOp, jop;
    bit eqCase, taken;
    arstN = 1'b0;
    memRsp.status = msBusy;
    memRsp.rdata = '0;
    errAddr = '1;
    for (int i = 0; i < 1024; i++) mem[i] = fillWord(32'(i) << 2);
    pc = '0;
    // round 0 uses equal operands for the set opcodes.
    for (int round = 0; round < 2; round++) begin
      a2 = randBits(32);
      a3 = (round == 0) ? a2 : randBits(32);
      loadImm(2, a2);
      loadImm(3, a3);
      foreach (aluOps[i]) begin
        a4 = randBits(32);
        imm = randBits(32);
        loadImm(4, a4);
        emit(aluOps[i], 4, 2, 3, imm, 1'b1);
        storeTo(4, refResult(aluOps[i], a4, a2, a3, imm), 1'b1);
      end
    end
    aB = randBits(32) | 32'd1;
    rB = randBits(32);
    loadImm(5, aB);
    loadImm(6, '0);
    loadImm(7, rB);
    for (int k = 0; k < 8; k++) begin
      eqCase = (k >= 4);
      cmpOp = (k % 2) ? opCmpImm : opCmp;
      jop = jumpOps[k % 4];
      rhs = eqCase ? aB : rB;
      emit(cmpOp, 5, eqCase ? 5 : 7, 0, rhs, 1'b1);
      flags = refResult(cmpOp, aB, rhs, '0, rhs);
      storeTo(1, flags, 1'b1);
      case (jop)
        opJumpFlagClr: taken = !flags[0];
        opJumpFlagSet: taken = flags[0];
        opJumpZero:    taken = eqCase; // r6 holds zero.
        default:       taken = !eqCase;
      endcase
      addr = pc + 32'd24;
      emit(jop, eqCase ? 6 : 5, 0, 0, addr, 1'b1);
      storeTo(5, aB, !taken);
      emit(opJump, 0, 0, 0, addr + 32'd8, !taken);
      storeTo(5, aB, taken);
    end
    addr = 32'h800 + (randBits(8) << 2);
    emit(opLoadAbs, 7, 0, 0, addr, 1'b1);
    storeTo(7, fillWord(addr), 1'b1);
    off = randBits(7) << 2;
    loadImm(9, off);
    emit(opLoadIdx, 8, 9, 0, 32'h800, 1'b1);
    storeTo(8, fillWord(32'h800 + off), 1'b1);
    addr = 32'h800 + (randBits(8) << 2);
    loadImm(11, addr);
    emit(opLoadReg, 10, 11, 0, '0, 1'b1);
    storeTo(10, fillWord(addr), 1'b1);
    // indexed store followed by a load of the same word.
    a2 = randBits(32);
    loadImm(12, a2);
    loadImm(13, nextStore - 32'hC00);
    emit(opStoreIdx, 13, 12, 0, 32'hC00, 1'b1);
    expectStore(nextStore, a2);
    emit(opLoadAbs, 14, 0, 0, nextStore, 1'b1);
    nextStore += 32'd4;
    storeTo(14, a2, 1'b1);
    addr = pc;
    emit(6'h3f, 0, 0, 0, '0, 1'b1);
    runProgram(hcIllegal, addr);
    // in the second run the jump target fetch answers with an error.
    pc = '0;
    loadImm(2, randBits(32));
    emit(opJump, 0, 0, 0, 32'h400, 1'b1);
    errAddr = 32'h400;
    readQ.push_back(errAddr);
    instrCount++;
    runProgram(hcFetch, errAddr);
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== list.f ====
rtl/cpuPkg.sv
rtl/cpuRegFile.sv
rtl/cpuExecute.sv
rtl/cpuSequencer.sv
rtl/cpuCore.sv
verification/cpuCore_asserts.sv
verification/cpuTb.sv
